/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := fpga_ctrl_tb
FILELIST  := fpga_ctrl_top.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard source/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* fpga_ctrl_top.f */
+incdir+sim
source/fpga_ctrl_pkg.sv
source/wb_if.sv
source/spi_reg_master.sv
source/fpga_reg_file.sv
source/led_blinker.sv
source/fpga_ctrl_top.sv
sim/fpga_ctrl_tb.sv

/* sim/spi_host.svh */
/*
 * SPI mode 0 host tasks for the testbench
 * full write and read frames, write aborted by chip select
 */
`ifndef SPI_HOST_SVH
`define SPI_HOST_SVH

localparam int SCK_HALF_CYCLES = 8;   // clk125M cycles per SCK half period

// sends one frame msb first, cs_n rises after sent_bits rising edges
task automatic shift_frame(input logic rd, input reg_addr_t addr, input reg_data_t wdata,
                           input int sent_bits, output reg_data_t rdata);
    logic [SPI_FRAME_BITS-1:0] frame;
    frame    = {rd, addr, wdata};
    rdata    = '0;
    spi_cs_n = 1'b0;
    spi_mosi = frame[SPI_FRAME_BITS-1];
    repeat (SCK_HALF_CYCLES) @(negedge clk125M);
    for (int i = 0; i < sent_bits; i++) begin
        if (i >= SPI_CMD_BITS) begin
            rdata = {rdata[14:0], spi_miso};   // settled since the last fall
        end
        spi_clk = 1'b1;
        repeat (SCK_HALF_CYCLES) @(negedge clk125M);
        spi_clk  = 1'b0;
        frame    = {frame[SPI_FRAME_BITS-2:0], 1'b0};
        spi_mosi = frame[SPI_FRAME_BITS-1];
        repeat (SCK_HALF_CYCLES) @(negedge clk125M);
    end
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    repeat (SCK_HALF_CYCLES) @(negedge clk125M);   // idle gap between frames
endtask

task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    reg_data_t discard;
    shift_frame(1'b0, addr, data, SPI_FRAME_BITS, discard);
endtask

task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
    shift_frame(1'b1, addr, 16'h0000, SPI_FRAME_BITS, data);
endtask

task automatic abort_write(input reg_addr_t addr, input reg_data_t data, input int sent_bits);
    reg_data_t discard;
    shift_frame(1'b0, addr, data, sent_bits, discard);
endtask

`endif

/* sim/fpga_ctrl_tb.sv */
/*
 * testbench for the control FPGA top level
 * SPI register access, reset values, aborted frames, debug LED timing
 */
`default_nettype none

module fpga_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fpga_ctrl_pkg::*;

    localparam int BLINK_HALF_MS   = 1;
    localparam int LED_HALF_CYCLES = BLINK_HALF_MS * 1000 * 125;   // ms, us per ms, clk per us
    localparam int TIMEOUT_CYCLES  = 400_000;   // two toggles plus ~55 frames of 400 clk

    logic        clk125M;
    logic        rst_n;
    logic        spi_clk;
    logic        spi_cs_n;
    logic        spi_mosi;
    logic        spi_miso;
    logic        mdio_in;
    logic        mdc;
    logic        mdio_out;
    logic        mdio_oe;
    logic        dbg_led;
    phy_vec_t    mac_link;
    phy_vec_t    eth_phy_rst_n;
    phy_vec_t    eth_rx_mask;

    logic [31:0] lcg_state;
    string       cur_test = "reset_values";
    int          err_count = 0;
    int          check_count = 0;
    int          errs_at_start = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          led_errs = 0;
    int          run_cycles = 0;
    int          rel_cycles = 0;   // rising edges since reset release
    int          toggle_at[$];
    reg_data_t   stored[$];
    reg_data_t   word;
    logic        led_prev = 1'b0;
    logic        led_exp;
    logic [12:0] ctrl_outs;

    `include "spi_host.svh"

    always #4 clk125M = ~clk125M;

    fpga_ctrl_top #(
        .BLINK_HALF_MS (BLINK_HALF_MS)
    ) UUT (
        .clk125M         (clk125M),
        .rst_n_i         (rst_n),
        .spi_clk_i       (spi_clk),
        .spi_cs_n_i      (spi_cs_n),
        .spi_mosi_i      (spi_mosi),
        .spi_miso_o      (spi_miso),
        .mdio_i          (mdio_in),
        .mdc_o           (mdc),
        .mdio_o          (mdio_out),
        .mdio_oe_o       (mdio_oe),
        .mac_link_i      (mac_link),
        .eth_phy_rst_n_o (eth_phy_rst_n),
        .eth_rx_mask_o   (eth_rx_mask),
        .dbg_led_o       (dbg_led)
    );

    // ----------------------------------------
    // cycle counters and LED watch
    // ----------------------------------------
    always @(posedge clk125M) begin
        run_cycles++;
        if (rst_n) begin
            rel_cycles++;
        end
        if (run_cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    always @(negedge clk125M) begin
        if (rst_n && dbg_led != led_prev) begin
            toggle_at.push_back(rel_cycles);
            led_prev = dbg_led;
        end
    end

    assign led_exp   = ((rel_cycles / LED_HALF_CYCLES) % 2) == 1;   // odd half periods lit
    assign ctrl_outs = {eth_phy_rst_n, eth_rx_mask, mdc, mdio_out, mdio_oe, spi_miso, dbg_led};

    reset_outputs: assert property (@(negedge clk125M) !rst_n |-> ctrl_outs == 13'h0000)
        else begin
            err_count++;
            $display("** Error [%s] outputs in reset: expected 0x0, actual 0x%0h",
                     cur_test, ctrl_outs);
        end

    led_timing: assert property (@(negedge clk125M) disable iff (!rst_n) dbg_led == led_exp)
        else begin
            err_count++;
            led_errs++;
            if (led_errs <= 3) begin
                $display("** Error [%s] dbg_led_o at cycle %0d: expected %0b, actual %0b",
                         cur_test, rel_cycles, led_exp, dbg_led);
            end
        end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic reg_data_t random_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];   // upper half is the better mixed
    endfunction

    function automatic reg_data_t output_for(input reg_addr_t addr);
        case (addr)
            REG_PHY_RST:     return {12'h000, eth_phy_rst_n};
            REG_ETH_RX_MASK: return {12'h000, eth_rx_mask};
            REG_MDIO_CLK:    return {15'h0000, mdc};
            REG_MDIO_DATA_O: return {15'h0000, mdio_out};
            REG_MDIO_DIR:    return {15'h0000, mdio_oe};
            default:         return 16'h0000;
        endcase
    endfunction

    task automatic expect_word(input string what, input reg_data_t exp, input reg_data_t got);
        check_count++;
        assert (got == exp) else begin
            err_count++;
            $display("** Error [%s] %s: expected 0x%04h, actual 0x%04h", cur_test, what, exp, got);
        end
    endtask

    task automatic compare_cycle(input string what, input int exp, input int got);
        check_count++;
        assert (got == exp) else begin
            err_count++;
            $display("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, exp, got);
        end
    endtask

    task automatic check_read(input string what, input reg_addr_t addr, input reg_data_t exp);
        reg_data_t got;
        read_reg(addr, got);
        expect_word(what, exp, got);
    endtask

    // write, then see the pin and the readback carry the low bits
    task automatic exercise_control(input string what, input reg_addr_t addr,
                                    input reg_data_t mask, input reg_data_t wdata);
        write_reg(addr, wdata);
        expect_word({what, " output"}, wdata & mask, output_for(addr));
        check_read({what, " readback"}, addr, wdata & mask);
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        errs_at_start = err_count;
    endtask

    task automatic report_test();
        if (err_count == errs_at_start) begin
            tests_passed++;
            $display("%s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", cur_test, err_count - errs_at_start);
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        clk125M   = 1'b0;
        rst_n     = 1'b0;
        spi_clk   = 1'b0;   // mode 0 idles low
        spi_cs_n  = 1'b1;
        spi_mosi  = 1'b0;
        mdio_in   = 1'b0;
        mac_link  = '0;
        lcg_state = 32'h997c;

        start_test("reset_values");
        repeat (8) @(negedge clk125M);
        rst_n = 1'b1;
        repeat (2) @(negedge clk125M);
        expect_word("eth_phy_rst_n_o", 16'h0000, {12'h000, eth_phy_rst_n});
        expect_word("eth_rx_mask_o", 16'h0000, {12'h000, eth_rx_mask});
        expect_word("mdc_o", 16'h0000, {15'h0000, mdc});
        expect_word("mdio_o", 16'h0000, {15'h0000, mdio_out});
        expect_word("mdio_oe_o", 16'h0000, {15'h0000, mdio_oe});
        expect_word("spi_miso_o", 16'h0000, {15'h0000, spi_miso});
        check_read("phy reset reg", REG_PHY_RST, 16'h0000);
        check_read("rx mask reg", REG_ETH_RX_MASK, 16'h0000);
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            check_read("test array", reg_addr_t'(REG_TEST_ARRAY + i), 16'h0000);
        end
        report_test();

        start_test("fw_and_status");
        check_read("fw date hi", REG_FW_DATE_HI, 16'h2024);
        check_read("fw date lo", REG_FW_DATE_LO, 16'h0611);
        check_read("fw type", REG_FW_TYPE, 16'h0001);
        for (int i = 0; i < 2; i++) begin
            word     = random_word();
            mac_link = word[3:0];
            check_read("mac link", REG_MAC_LINK, {12'h000, word[3:0]});
        end
        mdio_in = 1'b1;
        check_read("mdio in high", REG_MDIO_DATA_I, 16'h0001);
        mdio_in = 1'b0;
        check_read("mdio in low", REG_MDIO_DATA_I, 16'h0000);
        report_test();

        start_test("test_array");
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            word = random_word();
            stored.push_back(word);
            write_reg(reg_addr_t'(REG_TEST_ARRAY + i), word);
        end
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            check_read("test array readback", reg_addr_t'(REG_TEST_ARRAY + i), stored[i]);
        end
        check_read("unmapped 10", 7'd10, 16'h0000);
        check_read("unmapped 127", 7'd127, 16'h0000);
        write_reg(7'd20, random_word());   // just past the array
        check_read("unmapped 20 after write", 7'd20, 16'h0000);
        write_reg(REG_FW_DATE_HI, 16'h0000);
        check_read("fw date hi after write", REG_FW_DATE_HI, 16'h2024);
        write_reg(REG_MAC_LINK, ~{12'h000, mac_link});
        check_read("mac link after write", REG_MAC_LINK, {12'h000, mac_link});
        write_reg(REG_MDIO_DATA_I, 16'hffff);
        check_read("mdio in after write", REG_MDIO_DATA_I, 16'h0000);
        report_test();

        start_test("control_regs");
        word = random_word();   // second pass inverts every bit
        exercise_control("phy reset", REG_PHY_RST, 16'h000f, word);
        exercise_control("phy reset", REG_PHY_RST, 16'h000f, ~word);
        word = random_word();
        exercise_control("rx mask", REG_ETH_RX_MASK, 16'h000f, word);
        exercise_control("rx mask", REG_ETH_RX_MASK, 16'h000f, ~word);
        word = random_word();
        exercise_control("mdc", REG_MDIO_CLK, 16'h0001, word);
        exercise_control("mdc", REG_MDIO_CLK, 16'h0001, ~word);
        word = random_word();
        exercise_control("mdio out", REG_MDIO_DATA_O, 16'h0001, word);
        exercise_control("mdio out", REG_MDIO_DATA_O, 16'h0001, ~word);
        word = random_word();
        exercise_control("mdio dir", REG_MDIO_DIR, 16'h0001, word);
        exercise_control("mdio dir", REG_MDIO_DIR, 16'h0001, ~word);
        report_test();

        start_test("aborted_frame");
        write_reg(REG_ETH_RX_MASK, 16'h0005);
        abort_write(REG_ETH_RX_MASK, 16'h000a, 12);
        expect_word("rx mask after abort", 16'h0005, {12'h000, eth_rx_mask});
        check_read("rx mask readback after abort", REG_ETH_RX_MASK, 16'h0005);
        word = random_word();
        write_reg(REG_TEST_ARRAY, word);
        abort_write(REG_TEST_ARRAY, ~word, 12);
        check_read("test array after abort", REG_TEST_ARRAY, word);
        write_reg(REG_ETH_RX_MASK, 16'h000a);   // next full frame goes through
        expect_word("rx mask after full frame", 16'h000a, {12'h000, eth_rx_mask});
        check_read("rx mask readback", REG_ETH_RX_MASK, 16'h000a);
        report_test();

        start_test("led_blink");
        while (toggle_at.size() < 2) begin
            @(negedge clk125M);
        end
        compare_cycle("first toggle cycle", LED_HALF_CYCLES, toggle_at[0]);
        compare_cycle("second toggle cycle", 2 * LED_HALF_CYCLES, toggle_at[1]);
        report_test();

        $display("summary: %0d passed, %0d failed, %0d errors in %0d checks",
                 tests_passed, tests_failed, err_count, check_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/fpga_ctrl_pkg.sv */
/*
 * shared widths, types and register map of the control FPGA
 * firmware identification words and SPI frame layout
 */
`default_nettype none

package fpga_ctrl_pkg;

    // ----------------------------------------
    // widths and types
    // ----------------------------------------
    localparam int ETH_PORTS = 4;

    typedef logic [6:0]           reg_addr_t;
    typedef logic [15:0]          reg_data_t;
    typedef logic [ETH_PORTS-1:0] phy_vec_t;   // one bit per eth port

    // ----------------------------------------
    // SPI frame: rd flag, 7 addr bits, 16 data bits, msb first
    // ----------------------------------------
    localparam int SPI_FRAME_BITS = 24;
    localparam int SPI_CMD_BITS   = 8;
    localparam int SPI_CNT_W      = $clog2(SPI_FRAME_BITS);

    typedef logic [SPI_CNT_W-1:0] spi_cnt_t;

    typedef enum logic [1:0] {
        IDLE,
        CMD,    // shifting rd flag and address
        DATA,   // 16 data bits in or out
        DONE    // wait for cs_n to rise
    } spi_state_t;

    // firmware identification
    localparam reg_data_t FW_DATE_HI = 16'h2024;
    localparam reg_data_t FW_DATE_LO = 16'h0611;
    localparam reg_data_t FW_TYPE    = 16'h0001;

    // ----------------------------------------
    // register map, same address for rd and wr
    // ----------------------------------------
    localparam reg_addr_t REG_FW_DATE_HI  = 7'd0;
    localparam reg_addr_t REG_FW_DATE_LO  = 7'd1;
    localparam reg_addr_t REG_FW_TYPE     = 7'd2;
    localparam reg_addr_t REG_MAC_LINK    = 7'd3;   // read only
    localparam reg_addr_t REG_PHY_RST     = 7'd4;
    localparam reg_addr_t REG_MDIO_CLK    = 7'd5;
    localparam reg_addr_t REG_MDIO_DATA_O = 7'd6;
    localparam reg_addr_t REG_MDIO_DIR    = 7'd7;
    localparam reg_addr_t REG_MDIO_DATA_I = 7'd8;   // read only
    localparam reg_addr_t REG_ETH_RX_MASK = 7'd9;
    localparam reg_addr_t REG_TEST_ARRAY  = 7'd16;  // first entry
    localparam int        TEST_ARRAY_COUNT = 4;

    // led timing
    localparam int TICKS_PER_US = 125;   // clk125M cycles per us
    localparam int US_PER_MS    = 1000;

endpackage

`default_nettype wire

/* source/fpga_ctrl_top.sv */
/*
 * control FPGA top level: SPI register access and debug LED
 */
`default_nettype none

module fpga_ctrl_top #(
    parameter int BLINK_HALF_MS = 125
) (
    input  wire                     clk125M,
    input  wire                     rst_n_i,

    // host SPI port
    input  wire                     spi_clk_i,
    input  wire                     spi_cs_n_i,
    input  wire                     spi_mosi_i,
    output logic                    spi_miso_o,

    // MDIO, tristate buffer sits in the board wrapper
    input  wire                     mdio_i,
    output logic                    mdc_o,
    output logic                    mdio_o,
    output logic                    mdio_oe_o,

    // eth PHY control and status
    input  wire fpga_ctrl_pkg::phy_vec_t mac_link_i,
    output fpga_ctrl_pkg::phy_vec_t eth_phy_rst_n_o,
    output fpga_ctrl_pkg::phy_vec_t eth_rx_mask_o,

    output logic                    dbg_led_o
);

    wb_if wb ();

    // ----------------------------------------
    // register access
    // ----------------------------------------
    spi_reg_master u_spi (
        .clk125M    (clk125M),
        .rst_n_i    (rst_n_i),
        .spi_clk_i  (spi_clk_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_mosi_i (spi_mosi_i),
        .spi_miso_o (spi_miso_o),
        .wb         (wb)
    );

    fpga_reg_file u_regs (
        .clk125M         (clk125M),
        .rst_n_i         (rst_n_i),
        .mac_link_i      (mac_link_i),
        .mdio_i          (mdio_i),
        .eth_phy_rst_n_o (eth_phy_rst_n_o),
        .eth_rx_mask_o   (eth_rx_mask_o),
        .mdc_o           (mdc_o),
        .mdio_o          (mdio_o),
        .mdio_oe_o       (mdio_oe_o),
        .wb              (wb)
    );

    // ----------------------------------------
    // debug
    // ----------------------------------------
    led_blinker #(
        .BLINK_HALF_MS (BLINK_HALF_MS)
    ) u_led (
        .clk125M   (clk125M),
        .rst_n_i   (rst_n_i),
        .dbg_led_o (dbg_led_o)
    );

endmodule

`default_nettype wire

/* source/fpga_reg_file.sv */
/*
 * wishbone register bank: firmware id, link status, PHY reset,
 * bit-banged MDIO, eth rx mask and scratch test array
 */
`default_nettype none

module fpga_reg_file (
    input  wire                     clk125M,
    input  wire                     rst_n_i,
    input  wire fpga_ctrl_pkg::phy_vec_t mac_link_i,
    input  wire                     mdio_i,
    output fpga_ctrl_pkg::phy_vec_t eth_phy_rst_n_o,
    output fpga_ctrl_pkg::phy_vec_t eth_rx_mask_o,
    output logic                    mdc_o,
    output logic                    mdio_o,
    output logic                    mdio_oe_o,
    wb_if.slave                     wb
);
    import fpga_ctrl_pkg::*;

    phy_vec_t  mac_link_q;
    logic      mdio_in_q;
    reg_data_t test_array [TEST_ARRAY_COUNT];
    reg_data_t rd_data;
    logic      wr_en;

    // commit in the ack cycle, outputs move one clock later
    assign wr_en = wb.cyc & wb.stb & wb.ack & wb.we;

    // ----------------------------------------
    // status inputs and handshake
    // ----------------------------------------
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mac_link_q <= '0;
            mdio_in_q  <= 1'b0;
            wb.ack     <= 1'b0;
        end else begin
            mac_link_q <= mac_link_i;
            mdio_in_q  <= mdio_i;
            wb.ack     <= wb.cyc & wb.stb & ~wb.ack;   // never stalls
        end
    end

    always_ff @(posedge clk125M) begin
        if (wb.cyc && wb.stb && !wb.ack) begin
            wb.dat_r <= rd_data;
        end
    end

    // read mux, unmapped and unused bits read 0
    always_comb begin
        rd_data = '0;
        case (wb.adr)
            REG_FW_DATE_HI:  rd_data = FW_DATE_HI;
            REG_FW_DATE_LO:  rd_data = FW_DATE_LO;
            REG_FW_TYPE:     rd_data = FW_TYPE;
            REG_MAC_LINK:    rd_data[ETH_PORTS-1:0] = mac_link_q;
            REG_PHY_RST:     rd_data[ETH_PORTS-1:0] = eth_phy_rst_n_o;
            REG_MDIO_CLK:    rd_data[0] = mdc_o;
            REG_MDIO_DATA_O: rd_data[0] = mdio_o;
            REG_MDIO_DIR:    rd_data[0] = mdio_oe_o;
            REG_MDIO_DATA_I: rd_data[0] = mdio_in_q;
            REG_ETH_RX_MASK: rd_data[ETH_PORTS-1:0] = eth_rx_mask_o;
            default: ;
        endcase
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            if (wb.adr == reg_addr_t'(REG_TEST_ARRAY + i)) begin
                rd_data = test_array[i];
            end
        end
    end

    // ----------------------------------------
    // writable registers
    // ----------------------------------------
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            eth_phy_rst_n_o <= '0;   // all PHYs held in reset
            eth_rx_mask_o   <= '0;
            mdc_o           <= 1'b0;
            mdio_o          <= 1'b0;
            mdio_oe_o       <= 1'b0;
            for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
                test_array[i] <= '0;
            end
        end else if (wr_en) begin
            case (wb.adr)
                REG_PHY_RST:     eth_phy_rst_n_o <= wb.dat_w[ETH_PORTS-1:0];
                REG_MDIO_CLK:    mdc_o           <= wb.dat_w[0];
                REG_MDIO_DATA_O: mdio_o          <= wb.dat_w[0];
                REG_MDIO_DIR:    mdio_oe_o       <= wb.dat_w[0];
                REG_ETH_RX_MASK: eth_rx_mask_o   <= wb.dat_w[ETH_PORTS-1:0];
                default: ;   // read-only and unmapped ignored
            endcase
            for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
                if (wb.adr == reg_addr_t'(REG_TEST_ARRAY + i)) begin
                    test_array[i] <= wb.dat_w;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/led_blinker.sv */
/*
 * debug LED blinker with us and ms prescalers
 */
`default_nettype none

module led_blinker #(
    parameter int BLINK_HALF_MS = 125   // half blink period in ms
) (
    input  wire  clk125M,
    input  wire  rst_n_i,
    output logic dbg_led_o
);
    import fpga_ctrl_pkg::*;

    typedef logic [$clog2(TICKS_PER_US)-1:0]    us_cnt_t;
    typedef logic [$clog2(US_PER_MS)-1:0]       ms_cnt_t;
    typedef logic [$clog2(BLINK_HALF_MS+1)-1:0] half_cnt_t;

    us_cnt_t   us_cnt;
    ms_cnt_t   ms_cnt;
    half_cnt_t half_cnt;
    logic      us_tick;
    logic      ms_tick;

    assign us_tick = (us_cnt == us_cnt_t'(TICKS_PER_US - 1));
    assign ms_tick = us_tick & (ms_cnt == ms_cnt_t'(US_PER_MS - 1));

    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            us_cnt    <= '0;
            ms_cnt    <= '0;
            half_cnt  <= '0;
            dbg_led_o <= 1'b0;
        end else begin
            us_cnt <= us_tick ? '0 : us_cnt + 1'b1;
            if (us_tick) begin
                ms_cnt <= ms_tick ? '0 : ms_cnt + 1'b1;
            end
            if (ms_tick) begin
                if (half_cnt == half_cnt_t'(BLINK_HALF_MS - 1)) begin
                    half_cnt  <= '0;
                    dbg_led_o <= ~dbg_led_o;   // half period done
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/spi_reg_master.sv */
/*
 * SPI mode 0 slave, pins sampled in the clk125M domain
 * each 24-bit frame becomes one wishbone read or write
 */
`default_nettype none

module spi_reg_master (
    input  wire  clk125M,
    input  wire  rst_n_i,
    input  wire  spi_clk_i,
    input  wire  spi_cs_n_i,
    input  wire  spi_mosi_i,
    output logic spi_miso_o,
    wb_if.master wb
);
    import fpga_ctrl_pkg::*;

    logic [1:0] sck_sync;
    logic [1:0] cs_n_sync;
    logic [1:0] mosi_sync;
    logic       sck_d;
    logic       sck_rise;
    logic       sck_fall;
    logic       cs_active;
    logic       cmd_done;
    logic       frame_done;

    spi_state_t state;
    spi_cnt_t   bit_cnt;
    reg_data_t  rx_sr;     // incoming bits, cmd then data
    reg_data_t  tx_sr;     // read data going out on miso
    logic       cmd_rd;

    // ----------------------------------------
    // pin synchronizers and edge detect
    // ----------------------------------------
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sck_sync  <= '0;
            cs_n_sync <= '1;   // deselected
            mosi_sync <= '0;
            sck_d     <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], spi_clk_i};
            cs_n_sync <= {cs_n_sync[0], spi_cs_n_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
            sck_d     <= sck_sync[1];
        end
    end

    assign sck_rise  = sck_sync[1] & ~sck_d;
    assign sck_fall  = ~sck_sync[1] & sck_d;
    assign cs_active = ~cs_n_sync[1];

    // 8th and 24th rising edge of the frame
    assign cmd_done = cs_active & sck_rise & (state == CMD)
                      & (bit_cnt == spi_cnt_t'(SPI_CMD_BITS - 1));
    assign frame_done = cs_active & sck_rise & (state == DATA)
                        & (bit_cnt == spi_cnt_t'(SPI_FRAME_BITS - 1));

    // ----------------------------------------
    // receive shifter, bus address and write data
    // ----------------------------------------
    always_ff @(posedge clk125M) begin
        if (cs_active && sck_rise) begin
            rx_sr <= {rx_sr[14:0], mosi_sync[1]};
        end
        if (cmd_done) begin
            wb.adr <= {rx_sr[5:0], mosi_sync[1]};
        end
        if (frame_done) begin
            wb.dat_w <= {rx_sr[14:0], mosi_sync[1]};
        end
    end

    // ----------------------------------------
    // frame FSM and bus handshake
    // ----------------------------------------
    always_ff @(posedge clk125M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state      <= IDLE;
            bit_cnt    <= '0;
            cmd_rd     <= 1'b0;
            tx_sr      <= '0;
            spi_miso_o <= 1'b0;
            wb.cyc     <= 1'b0;
            wb.stb     <= 1'b0;
            wb.we      <= 1'b0;
        end else begin
            // one cycle in flight, closed in the clock after ack
            if (wb.cyc && wb.ack) begin
                wb.cyc <= 1'b0;
                wb.stb <= 1'b0;
                if (!wb.we) begin
                    tx_sr <= wb.dat_r;
                end
            end

            if (!cs_active) begin
                state      <= IDLE;   // also aborts a partial frame
                bit_cnt    <= '0;
                spi_miso_o <= 1'b0;
            end else begin
                case (state)
                    IDLE: begin
                        state   <= CMD;
                        bit_cnt <= '0;
                    end
                    CMD: begin
                        if (sck_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        if (cmd_done) begin
                            cmd_rd <= rx_sr[6];   // first bit of the frame
                            state  <= DATA;
                            if (rx_sr[6]) begin
                                wb.cyc <= 1'b1;   // read right away
                                wb.stb <= 1'b1;
                                wb.we  <= 1'b0;
                            end
                        end
                    end
                    DATA: begin
                        if (sck_fall && cmd_rd) begin
                            spi_miso_o <= tx_sr[15];
                            tx_sr      <= {tx_sr[14:0], 1'b0};
                        end
                        if (sck_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        if (frame_done) begin
                            state <= DONE;
                            if (!cmd_rd) begin
                                wb.cyc <= 1'b1;
                                wb.stb <= 1'b1;
                                wb.we  <= 1'b1;
                            end
                        end
                    end
                    DONE: begin
                        bit_cnt <= '0;   // held until cs_n goes high
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/wb_if.sv */
/*
 * wishbone classic bus between the SPI master and the register bank
 */
`default_nettype none

interface wb_if;
    import fpga_ctrl_pkg::*;

    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    reg_data_t dat_w;
    reg_data_t dat_r;   // valid with ack on reads
    logic      ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire
